// File: all.f
src/unified_cache_pkg.sv
src/fifo_queue.sv
src/priority_arbiter.sv
src/unified_cache_bank.sv
src/unified_cache.sv
verif/unified_cache_checker.sv
verif/unified_cache_tb.sv

// File: verif/unified_cache_tb.sv
`default_nettype none
`timescale 1ns/100ps

module unified_cache_tb
    import unified_cache_pkg::*;
();

    localparam int ack_limit   = 40;
    localparam int drain_limit = 200;
    localparam int num_rows    = 12;

    logic                      clk_in;
    logic                      rst_n;
    logic [num_input_port-1:0] in_valid;
    logic [num_input_port-1:0] in_write;
    addr_t                     in_addr  [num_input_port-1:0];
    data_t                     in_wdata [num_input_port-1:0];
    logic [num_input_port-1:0] in_ack;
    logic [num_input_port-1:0] out_valid;
    logic [num_input_port-1:0] out_write;
    data_t                     out_rdata [num_input_port-1:0];
    logic [num_input_port-1:0] out_ack;
    logic                      mem_req_valid;
    mem_op_t                   mem_req_op;
    addr_t                     mem_req_addr;
    data_t                     mem_req_wdata;
    logic                      mem_req_ack;
    logic                      mem_rsp_valid;
    data_t                     mem_rsp_data;
    logic                      mem_rsp_ack;

    // test, issue with next row, port, write, expect miss, addr, wdata
    logic [50:0] stim [0:num_rows-1];
    data_t       memory [addr_t];
    data_t       shadow [addr_t];
    integer      seed = 32'h095c_6d2b;
    logic        ok;

    unified_cache unified_cache_inst (.*);

    unified_cache_checker response_check (.*);

    initial
        clk_in = 1'b0;

    always
        #50 clk_in = ~clk_in;

    function automatic data_t initial_word(input addr_t a);
        return data_t'(a) ^ 32'h5a5a_0000;
    endfunction

    task automatic predict(input port_t p, input logic w, input logic miss,
                           input addr_t a, input data_t d);
        if (w)
        begin
            shadow[a] = d;
            response_check.expect_memory(mem_write, a, d);
        end
        else if (miss)
            response_check.expect_memory(mem_read, a, '0);
        response_check.expect_response(p, w,
                                       shadow.exists(a) ? shadow[a] : initial_word(a));
    endtask

    task automatic apply_row(input logic [50:0] row);
        port_t p;
        begin
            p = row[46];
            in_valid[p] = 1'b1;
            in_write[p] = row[45];
            in_addr[p]  = row[43:32];
            in_wdata[p] = row[31:0];
            predict(p, row[45], row[44], row[43:32], row[31:0]);
        end
    endtask

    task automatic hand_over(input logic [num_input_port-1:0] mask);
        logic [num_input_port-1:0] acked;
        int                        n;
        begin
            acked = '0;
            n     = 0;
            // ack seen at a falling edge means transfer at the next rising edge
            while (acked != mask && n < ack_limit)
            begin
                acked = acked | (in_ack & mask);
                @(negedge clk_in);
                in_valid = in_valid & ~acked;
                n++;
            end
            if (acked != mask)
            begin
                ok = 1'b0;
                response_check.report_failure("in_ack stayed low for a waiting request");
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        begin
            n = 0;
            while (response_check.outstanding() != 0 && n < drain_limit)
            begin
                @(negedge clk_in);
                n++;
            end
            if (response_check.outstanding() != 0)
            begin
                ok = 1'b0;
                response_check.report_failure("timed out waiting for a response or memory request");
            end
        end
    endtask

    task automatic run_backpressure();
        int   k;
        int   n;
        logic blocked;
        begin
            k          = 0;
            blocked    = 1'b0;
            out_ack[1] = 1'b0;
            while (!blocked && k < 8)
            begin
                apply_row({3'd6, 1'b0, 1'b1, 1'b0, 1'b1, addr_t'(12'h5d0 + k), 32'h0});
                n = 0;
                while (!in_ack[1] && n < 20)
                begin
                    @(negedge clk_in);
                    n++;
                end
                if (in_ack[1])
                begin
                    @(negedge clk_in);
                    k++;
                end
                else
                    blocked = 1'b1;
            end
            out_ack[1] = 1'b1;
            // the blocked request is still held and goes in once space frees up
            if (blocked)
                hand_over(2'b10);
            else
            begin
                in_valid[1] = 1'b0;
                ok          = 1'b0;
                response_check.report_failure("in_ack on port 1 never fell while responses were held");
            end
            if (ok)
                wait_drain();
            response_check.close_test(6);
        end
    endtask

    task automatic serve_memory();
        addr_t   a;
        data_t   d;
        mem_op_t op;
        int      n;
        begin
            repeat ($unsigned($random(seed)) % 4)
                @(negedge clk_in);
            a           = mem_req_addr;
            d           = mem_req_wdata;
            op          = mem_req_op;
            mem_req_ack = 1'b1;
            @(negedge clk_in);
            mem_req_ack = 1'b0;
            if (op == mem_write)
                memory[a] = d;
            else
            begin
                repeat ($unsigned($random(seed)) % 4)
                    @(negedge clk_in);
                mem_rsp_data  = memory.exists(a) ? memory[a] : initial_word(a);
                mem_rsp_valid = 1'b1;
                n = 0;
                while (!mem_rsp_ack && n < ack_limit)
                begin
                    @(negedge clk_in);
                    n++;
                end
                if (!mem_rsp_ack)
                begin
                    ok = 1'b0;
                    response_check.report_failure("mem_rsp_ack never rose for a read response");
                end
                @(negedge clk_in);
                mem_rsp_valid = 1'b0;
            end
        end
    endtask

    // next-level memory, one request at a time
    initial
    begin
        mem_req_ack   = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        forever
        begin
            @(negedge clk_in);
            if (rst_n && mem_req_valid)
                serve_memory();
        end
    end

    initial
    begin
        int                        i;
        int                        last;
        logic [num_input_port-1:0] mask;
        rst_n    = 1'b0;
        in_valid = '0;
        in_write = '0;
        out_ack  = '1;
        for (int p = 0; p < num_input_port; p++)
        begin
            in_addr[p]  = '0;
            in_wdata[p] = '0;
        end
        stim = '{
            {3'd1, 1'b0, 1'b0, 1'b0, 1'b1, 12'h013, 32'h0},
            {3'd1, 1'b0, 1'b0, 1'b0, 1'b0, 12'h013, 32'h0},
            {3'd2, 1'b0, 1'b1, 1'b1, 1'b0, 12'h013, 32'hcafe_0013},
            {3'd2, 1'b0, 1'b1, 1'b0, 1'b0, 12'h013, 32'h0},
            {3'd3, 1'b0, 1'b0, 1'b1, 1'b0, 12'h2a7, 32'h1234_5678},
            {3'd3, 1'b0, 1'b0, 1'b0, 1'b1, 12'h2a7, 32'h0},
            {3'd4, 1'b0, 1'b0, 1'b0, 1'b1, 12'h035, 32'h0},
            {3'd4, 1'b0, 1'b1, 1'b0, 1'b1, 12'h135, 32'h0},
            {3'd4, 1'b0, 1'b0, 1'b0, 1'b1, 12'h035, 32'h0},
            {3'd4, 1'b0, 1'b1, 1'b0, 1'b1, 12'h135, 32'h0},
            {3'd5, 1'b1, 1'b0, 1'b0, 1'b1, 12'h048, 32'h0},
            {3'd5, 1'b0, 1'b1, 1'b0, 1'b1, 12'h0c9, 32'h0}
        };
        ok = 1'b1;
        repeat (2) @(negedge clk_in);
        rst_n = 1'b1;
        @(negedge clk_in);
        i = 0;
        while (i < num_rows && ok)
        begin
            // rows flagged for simultaneous issue go out together
            last = i;
            while (stim[last][47] && last < num_rows - 1)
                last++;
            mask = '0;
            for (int r = i; r <= last; r++)
            begin
                apply_row(stim[r]);
                mask[stim[r][46]] = 1'b1;
            end
            hand_over(mask);
            if (ok)
                wait_drain();
            if (last == num_rows - 1 || stim[last+1][50:48] != stim[i][50:48])
                response_check.close_test(stim[i][50:48]);
            i = last + 1;
        end
        if (ok)
            run_backpressure();
        response_check.report_counts();
        if (ok && response_check.error_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/unified_cache_checker.sv
`default_nettype none
`timescale 1ns/100ps

module unified_cache_checker
    import unified_cache_pkg::*;
(
    input logic                      clk_in,
    input logic                      rst_n,
    input logic [num_input_port-1:0] out_valid,
    input logic [num_input_port-1:0] out_write,
    input data_t                     out_rdata [num_input_port-1:0],
    input logic [num_input_port-1:0] out_ack,
    input logic                      mem_req_valid,
    input mem_op_t                   mem_req_op,
    input addr_t                     mem_req_addr,
    input data_t                     mem_req_wdata,
    input logic                      mem_req_ack
);

    // expected responses in issue order, tagged with their port
    port_t   rsp_port  [$];
    logic    rsp_write [$];
    data_t   rsp_data  [$];
    mem_op_t mem_op    [$];
    addr_t   mem_addr  [$];
    data_t   mem_data  [$];

    int error_count   = 0;
    int check_count   = 0;
    int mem_reads     = 0;
    int test_count    = 0;
    int errors_before = 0;

    task automatic expect_response(input port_t p, input logic w, input data_t d);
        rsp_port.push_back(p);
        rsp_write.push_back(w);
        rsp_data.push_back(d);
    endtask

    task automatic expect_memory(input mem_op_t op, input addr_t a, input data_t d);
        mem_op.push_back(op);
        mem_addr.push_back(a);
        mem_data.push_back(d);
    endtask

    function automatic int outstanding();
        return rsp_port.size() + mem_op.size();
    endfunction

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s (at %0t)", msg, $time);
    endtask

    task automatic close_test(input int id);
        test_count++;
        if (error_count == errors_before)
            $display("test %0d: ok", id);
        else
            $display("test %0d: failed with %0d errors", id, error_count - errors_before);
        errors_before = error_count;
    endtask

    task automatic report_counts();
        $display("tests %0d, checks %0d, memory reads %0d, errors %0d",
                 test_count, check_count, mem_reads, error_count);
    endtask

    task automatic check_response(input port_t p);
        int i;
        begin
            i = 0;
            // oldest expectation for this port
            while (i < rsp_port.size() && rsp_port[i] != p)
                i++;
            check_count++;
            if (i == rsp_port.size())
                report_failure($sformatf("response arrived on port %0d with none pending", p));
            else
            begin
                if (out_rdata[p] !== rsp_data[i] || out_write[p] !== rsp_write[i])
                begin
                    error_count++;
                    $display("mismatch at %0t: port %0d gave %h write %b, expected %h write %b",
                             $time, p, out_rdata[p], out_write[p], rsp_data[i], rsp_write[i]);
                end
                rsp_port.delete(i);
                rsp_write.delete(i);
                rsp_data.delete(i);
            end
        end
    endtask

    task automatic check_memory();
        check_count++;
        if (mem_req_op == mem_read)
            mem_reads++;
        if (mem_op.size() == 0)
            report_failure($sformatf("memory request to %h that no test expected", mem_req_addr));
        else
        begin
            // write data only matters for writes
            if (mem_req_op !== mem_op[0] || mem_req_addr !== mem_addr[0] ||
                (mem_req_op == mem_write && mem_req_wdata !== mem_data[0]))
            begin
                error_count++;
                $display("mismatch at %0t: memory %s %h data %h, expected %s %h data %h",
                         $time, (mem_req_op == mem_read) ? "read" : "write", mem_req_addr,
                         mem_req_wdata, (mem_op[0] == mem_read) ? "read" : "write",
                         mem_addr[0], mem_data[0]);
            end
            void'(mem_op.pop_front());
            void'(mem_addr.pop_front());
            void'(mem_data.pop_front());
        end
    endtask

    always @(posedge clk_in)
    begin
        if (rst_n)
        begin
            for (int p = 0; p < num_input_port; p++)
                if (out_valid[p] && out_ack[p])
                    check_response(port_t'(p));
            if (mem_req_valid && mem_req_ack)
                check_memory();
        end
    end

endmodule

`default_nettype wire

// File: src/unified_cache.sv
`default_nettype none
`timescale 1ns/100ps

module unified_cache
    import unified_cache_pkg::*;
(
    input  logic                      clk_in,
    input  logic                      rst_n,

    // requester inputs
    input  logic [num_input_port-1:0] in_valid,
    input  logic [num_input_port-1:0] in_write,
    input  addr_t                     in_addr  [num_input_port-1:0],
    input  data_t                     in_wdata [num_input_port-1:0],
    output logic [num_input_port-1:0] in_ack,

    // responses
    output logic [num_input_port-1:0] out_valid,
    output logic [num_input_port-1:0] out_write,
    output data_t                     out_rdata [num_input_port-1:0],
    input  logic [num_input_port-1:0] out_ack,

    // next-level memory request
    output logic                      mem_req_valid,
    output mem_op_t                   mem_req_op,
    output addr_t                     mem_req_addr,
    output data_t                     mem_req_wdata,
    input  logic                      mem_req_ack,

    // next-level memory response
    input  logic                      mem_rsp_valid,
    input  data_t                     mem_rsp_data,
    output logic                      mem_rsp_ack
);

    logic [num_input_port-1:0] q_valid;
    logic [num_input_port-1:0] q_write;
    logic [num_input_port-1:0] q_full;
    addr_t                     q_addr  [num_input_port-1:0];
    data_t                     q_wdata [num_input_port-1:0];
    logic [num_input_port-1:0] q_ack;

    logic  arb_valid;
    logic  arb_write;
    addr_t arb_addr;
    data_t arb_wdata;
    port_t arb_port;
    logic  arb_ack;

    genvar gen;

    // one queue per requester
    for (gen = 0; gen < num_input_port; gen = gen + 1)
    begin : input_queue
        fifo_queue queue
        (
            .clk_in   (clk_in),
            .rst_n    (rst_n),
            .in_valid (in_valid[gen]),
            .in_write (in_write[gen]),
            .in_addr  (in_addr[gen]),
            .in_wdata (in_wdata[gen]),
            .in_ack   (in_ack[gen]),
            .q_valid  (q_valid[gen]),
            .q_write  (q_write[gen]),
            .q_addr   (q_addr[gen]),
            .q_wdata  (q_wdata[gen]),
            .q_full   (q_full[gen]),
            .q_ack    (q_ack[gen])
        );
    end

    // full queues act as critical requests
    priority_arbiter input_arbiter
    (
        .q_valid   (q_valid),
        .q_write   (q_write),
        .q_full    (q_full),
        .q_addr    (q_addr),
        .q_wdata   (q_wdata),
        .q_ack     (q_ack),
        .arb_valid (arb_valid),
        .arb_write (arb_write),
        .arb_addr  (arb_addr),
        .arb_wdata (arb_wdata),
        .arb_port  (arb_port),
        .arb_ack   (arb_ack)
    );

    unified_cache_bank cache_bank
    (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .arb_valid     (arb_valid),
        .arb_write     (arb_write),
        .arb_addr      (arb_addr),
        .arb_wdata     (arb_wdata),
        .arb_port      (arb_port),
        .arb_ack       (arb_ack),
        .out_valid     (out_valid),
        .out_write     (out_write),
        .out_rdata     (out_rdata),
        .out_ack       (out_ack),
        .mem_req_valid (mem_req_valid),
        .mem_req_op    (mem_req_op),
        .mem_req_addr  (mem_req_addr),
        .mem_req_wdata (mem_req_wdata),
        .mem_req_ack   (mem_req_ack),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_ack   (mem_rsp_ack)
    );

endmodule

`default_nettype wire

// File: src/unified_cache_bank.sv
`default_nettype none
`timescale 1ns/100ps

module unified_cache_bank
    import unified_cache_pkg::*;
(
    input  logic                      clk_in,
    input  logic                      rst_n,

    input  logic                      arb_valid,
    input  logic                      arb_write,
    input  addr_t                     arb_addr,
    input  data_t                     arb_wdata,
    input  port_t                     arb_port,
    output logic                      arb_ack,

    output logic [num_input_port-1:0] out_valid,
    output logic [num_input_port-1:0] out_write,
    output data_t                     out_rdata [num_input_port-1:0],
    input  logic [num_input_port-1:0] out_ack,

    output logic                      mem_req_valid,
    output mem_op_t                   mem_req_op,
    output addr_t                     mem_req_addr,
    output data_t                     mem_req_wdata,
    input  logic                      mem_req_ack,

    input  logic                      mem_rsp_valid,
    input  data_t                     mem_rsp_data,
    output logic                      mem_rsp_ack
);

    bank_state_t state;
    bank_state_t state_next;

    // registered request
    logic  req_write;
    addr_t req_addr;
    data_t req_wdata;
    port_t req_port;

    // line storage
    logic [num_lines-1:0] line_valid;
    tag_t                 line_tag  [num_lines-1:0];
    data_t                line_data [num_lines-1:0];

    data_t  rsp_data;
    index_t req_index;
    tag_t   req_tag;
    logic   hit;
    logic   accept;

    assign req_index = req_addr[index_width-1:0];
    assign req_tag   = req_addr[addr_width-1:index_width];
    assign hit       = line_valid[req_index] && (line_tag[req_index] == req_tag);

    assign arb_ack = (state == st_idle);
    assign accept  = arb_valid && arb_ack;

    assign mem_req_valid = (state == st_mem_req);
    assign mem_req_op    = req_write ? mem_write : mem_read;
    assign mem_req_addr  = req_addr;
    assign mem_req_wdata = req_wdata;
    assign mem_rsp_ack   = (state == st_mem_wait);

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
            begin
                if (arb_valid)
                    state_next = st_lookup;
            end
            st_lookup:
            begin
                // writes always go through to memory
                if (req_write || !hit)
                    state_next = st_mem_req;
                else
                    state_next = st_respond;
            end
            st_mem_req:
            begin
                if (mem_req_ack)
                    state_next = req_write ? st_respond : st_mem_wait;
            end
            st_mem_wait:
            begin
                if (mem_rsp_valid)
                    state_next = st_respond;
            end
            st_respond:
            begin
                if (out_ack[req_port])
                    state_next = st_idle;
            end
            default:
            begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk_in or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= st_idle;
            line_valid <= '0;
        end
        else
        begin
            state <= state_next;
            if (state == st_mem_wait && mem_rsp_valid)
                line_valid[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept)
        begin
            req_write <= arb_write;
            req_addr  <= arb_addr;
            req_wdata <= arb_wdata;
            req_port  <= arb_port;
        end

        if (state == st_lookup)
        begin
            if (req_write)
            begin
                // update on hit only, no allocate on write miss
                if (hit)
                    line_data[req_index] <= req_wdata;
                rsp_data <= req_wdata;
            end
            else if (hit)
            begin
                rsp_data <= line_data[req_index];
            end
        end

        // miss fill
        if (state == st_mem_wait && mem_rsp_valid)
        begin
            line_tag[req_index]  <= req_tag;
            line_data[req_index] <= mem_rsp_data;
            rsp_data             <= mem_rsp_data;
        end
    end

    // response goes only to the requesting port
    always_comb
    begin
        out_valid = '0;
        if (state == st_respond)
            out_valid[req_port] = 1'b1;
        for (int p = 0; p < num_input_port; p++)
        begin
            out_write[p] = req_write;
            out_rdata[p] = rsp_data;
        end
    end

endmodule

`default_nettype wire

// File: src/priority_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module priority_arbiter
    import unified_cache_pkg::*;
(
    input  logic [num_input_port-1:0] q_valid,
    input  logic [num_input_port-1:0] q_write,
    input  logic [num_input_port-1:0] q_full,
    input  addr_t                     q_addr  [num_input_port-1:0],
    input  data_t                     q_wdata [num_input_port-1:0],
    output logic [num_input_port-1:0] q_ack,

    output logic                      arb_valid,
    output logic                      arb_write,
    output addr_t                     arb_addr,
    output data_t                     arb_wdata,
    output port_t                     arb_port,
    input  logic                      arb_ack
);

    logic  found;
    port_t grant;

    always_comb
    begin
        found = 1'b0;
        grant = '0;
        // a full queue is critical and goes first
        for (int i = 0; i < num_input_port; i++)
        begin
            if (!found && q_full[i])
            begin
                found = 1'b1;
                grant = port_t'(i);
            end
        end
        // otherwise lowest index wins
        for (int i = 0; i < num_input_port; i++)
        begin
            if (!found && q_valid[i])
            begin
                found = 1'b1;
                grant = port_t'(i);
            end
        end
    end

    assign arb_valid = found;
    assign arb_write = q_write[grant];
    assign arb_addr  = q_addr[grant];
    assign arb_wdata = q_wdata[grant];
    assign arb_port  = grant;

    always_comb
    begin
        q_ack = '0;
        if (found)
            q_ack[grant] = arb_ack;
    end

endmodule

`default_nettype wire

// File: src/fifo_queue.sv
`default_nettype none
`timescale 1ns/100ps

module fifo_queue
    import unified_cache_pkg::*;
(
    input  logic  clk_in,
    input  logic  rst_n,

    input  logic  in_valid,
    input  logic  in_write,
    input  addr_t in_addr,
    input  data_t in_wdata,
    output logic  in_ack,

    output logic  q_valid,
    output logic  q_write,
    output addr_t q_addr,
    output data_t q_wdata,
    output logic  q_full,
    input  logic  q_ack
);

    logic  entry_write [queue_depth-1:0];
    addr_t entry_addr  [queue_depth-1:0];
    data_t entry_wdata [queue_depth-1:0];

    logic [queue_ptr_width-1:0]   wr_ptr;
    logic [queue_ptr_width-1:0]   rd_ptr;
    logic [queue_count_width-1:0] count;

    logic push;
    logic pop;

    assign q_full  = (count == queue_count_width'(queue_depth));
    assign q_valid = (count != '0);
    assign in_ack  = ~q_full;

    assign push = in_valid & in_ack;
    assign pop  = q_valid & q_ack;

    // head entry is shown directly
    assign q_write = entry_write[rd_ptr];
    assign q_addr  = entry_addr[rd_ptr];
    assign q_wdata = entry_wdata[rd_ptr];

    always_ff @(posedge clk_in)
    begin
        if (push)
        begin
            entry_write[wr_ptr] <= in_write;
            entry_addr[wr_ptr]  <= in_addr;
            entry_wdata[wr_ptr] <= in_wdata;
        end
    end

    always_ff @(posedge clk_in or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                if (wr_ptr == queue_ptr_width'(queue_depth - 1))
                    wr_ptr <= '0;
                else
                    wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop)
            begin
                if (rd_ptr == queue_ptr_width'(queue_depth - 1))
                    rd_ptr <= '0;
                else
                    rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/unified_cache_pkg.sv
`default_nettype none

package unified_cache_pkg;

    localparam int num_input_port = 2;
    localparam int addr_width     = 12;
    localparam int data_width     = 32;
    localparam int index_width    = 4;
    localparam int tag_width      = addr_width - index_width;
    localparam int num_lines      = 1 << index_width;
    localparam int queue_depth    = 4;

    // pointer and occupancy widths for the input queues
    localparam int queue_ptr_width   = $clog2(queue_depth);
    localparam int queue_count_width = $clog2(queue_depth + 1);

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;
    typedef logic [$clog2(num_input_port)-1:0] port_t;
    typedef logic [index_width-1:0] index_t;
    typedef logic [tag_width-1:0] tag_t;

    typedef enum logic [2:0]
    {
        st_idle,
        st_lookup,
        st_mem_req,
        st_mem_wait,
        st_respond
    } bank_state_t;

    typedef enum logic [0:0]
    {
        mem_read,
        mem_write
    } mem_op_t;

endpackage

`default_nettype wire
